/* Makefile */
SOURCES = sim.f \
	include/hysteresis_golden.svh \
	logic/edge_pkg.sv \
	logic/pixel_fifo.sv \
	logic/hysteresis.sv \
	logic/edge_link_top.sv \
	tb/edge_link_tb.sv

SIM_BIN = obj_dir/Vedge_link_tb

.PHONY: all run clean

all: $(SIM_BIN)

# The binary is rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES)
	verilator --binary --timing -j 0 -Wno-fatal --top-module edge_link_tb -f sim.f

# A $fatal in the testbench makes the binary exit with a failing status
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf obj_dir

/* logic/edge_link_top.sv */
module edge_link_top #(
    parameter int WIDTH = 1280,
    parameter int HEIGHT = 720,
    parameter int FIFO_DEPTH = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_wr_en,
    input  edge_pkg::pixel_t in_din,
    output logic             in_full,
    input  logic             out_rd_en,
    output edge_pkg::pixel_t out_dout,
    output logic             out_empty
);

    // Read side of the input FIFO, driven by the hysteresis block
    logic             in_rd_en;
    logic             in_empty;
    edge_pkg::pixel_t in_dout;

    // Write side of the output FIFO, driven by the hysteresis block
    logic             out_wr_en;
    logic             out_full;
    edge_pkg::pixel_t out_din;

    pixel_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_in_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(in_wr_en),
        .din(in_din),
        .full(in_full),
        .rd_en(in_rd_en),
        .dout(in_dout),
        .empty(in_empty)
    );

    hysteresis #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT)
    ) u_hysteresis (
        .clock(clock),
        .reset(reset),
        .in_rd_en(in_rd_en),
        .in_empty(in_empty),
        .in_dout(in_dout),
        .out_wr_en(out_wr_en),
        .out_full(out_full),
        .out_din(out_din)
    );

    pixel_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_out_fifo (
        .clock(clock),
        .reset(reset),
        .wr_en(out_wr_en),
        .din(out_din),
        .full(out_full),
        .rd_en(out_rd_en),
        .dout(out_dout),
        .empty(out_empty)
    );

endmodule

/* logic/edge_pkg.sv */
package edge_pkg;

    // One gradient magnitude on the input side, one edge pixel on the output side
    typedef logic [7:0] pixel_t;

    // A pixel strictly above this level is a strong edge
    localparam pixel_t high_threshold = 8'd48;

    // A pixel strictly above this level and not strong is a weak edge
    localparam pixel_t low_threshold = 8'd12;

    // Phases of the hysteresis block
    //   prologue fills the window with the first WIDTH+2 pixels of a frame
    //   decide evaluates the pixel at the window centre
    //   emit hands the decision to the output FIFO
    typedef enum logic [1:0] {
        prologue,
        decide,
        emit
    } hysteresis_state_t;

endpackage

/* logic/hysteresis.sv */
module hysteresis #(
    parameter int WIDTH = 1280,
    parameter int HEIGHT = 720
) (
    input  logic             clock,
    input  logic             reset,
    output logic             in_rd_en,
    input  logic             in_empty,
    input  edge_pkg::pixel_t in_dout,
    output logic             out_wr_en,
    input  logic             out_full,
    output edge_pkg::pixel_t out_din
);

    // Window geometry
    // Entry TAPS-1 takes the newest pixel and entry 0 holds the oldest one
    localparam int TAPS = 2 * WIDTH + 3;
    localparam int CENTRE = WIDTH + 1;
    localparam int PIXELS = WIDTH * HEIGHT;

    localparam int COL_BITS = (WIDTH > 1) ? $clog2(WIDTH) : 1;
    localparam int ROW_BITS = (HEIGHT > 1) ? $clog2(HEIGHT) : 1;
    localparam int COUNT_BITS = $clog2(PIXELS + 1);

    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(WIDTH - 1);
    localparam logic [ROW_BITS-1:0] LAST_ROW = ROW_BITS'(HEIGHT - 1);

    // The read that brings the count to WIDTH+2 closes the prologue
    localparam logic [COUNT_BITS-1:0] PROLOGUE_LAST = COUNT_BITS'(WIDTH + 1);
    localparam logic [COUNT_BITS-1:0] FRAME_LEN = COUNT_BITS'(PIXELS);

    edge_pkg::hysteresis_state_t state;

    // Position of the pixel at the window centre
    logic [COL_BITS-1:0] col;
    logic [ROW_BITS-1:0] row;

    // Input pixels taken from the input FIFO in the current frame
    logic [COUNT_BITS-1:0] read_count;

    edge_pkg::pixel_t shift_reg [TAPS];
    edge_pkg::pixel_t result;

    logic             frame_read;
    logic             shift_en;
    edge_pkg::pixel_t shift_in;
    edge_pkg::pixel_t centre;
    logic             border;
    logic             last_pixel;
    logic             centre_strong;
    logic             centre_weak;
    logic             neighbour_strong;
    edge_pkg::pixel_t decision;

    // Once all pixels of a frame are in, zeros are padded to drain the last rows
    assign frame_read = (read_count == FRAME_LEN);

    // The prologue reads whenever it can, decide reads once per pixel until the
    // frame is exhausted and emit never reads
    assign in_rd_en = !in_empty &&
                      ((state == edge_pkg::prologue) ||
                       (state == edge_pkg::decide && !frame_read));

    assign shift_en = in_rd_en || (state == edge_pkg::decide && frame_read);
    assign shift_in = in_rd_en ? in_dout : '0;

    // Hold the write while the output FIFO has no room
    assign out_wr_en = (state == edge_pkg::emit) && !out_full;
    assign out_din = result;

    assign centre = shift_reg[CENTRE];

    assign border = (row == '0) || (row == LAST_ROW) ||
                    (col == '0) || (col == LAST_COL);

    assign last_pixel = (row == LAST_ROW) && (col == LAST_COL);

    assign centre_strong = centre > edge_pkg::high_threshold;
    assign centre_weak = centre > edge_pkg::low_threshold;

    // Row above sits at entries 0 to 2, the row below at 2*WIDTH to 2*WIDTH+2
    always_comb begin
        neighbour_strong = (shift_reg[0] > edge_pkg::high_threshold) ||
                           (shift_reg[1] > edge_pkg::high_threshold) ||
                           (shift_reg[2] > edge_pkg::high_threshold) ||
                           (shift_reg[WIDTH] > edge_pkg::high_threshold) ||
                           (shift_reg[WIDTH + 2] > edge_pkg::high_threshold) ||
                           (shift_reg[2 * WIDTH] > edge_pkg::high_threshold) ||
                           (shift_reg[2 * WIDTH + 1] > edge_pkg::high_threshold) ||
                           (shift_reg[2 * WIDTH + 2] > edge_pkg::high_threshold);
    end

    // Keep a strong centre, or a weak one that touches a strong neighbour
    always_comb begin
        if (border) begin
            decision = '0;
        end else if (centre_strong || (centre_weak && neighbour_strong)) begin
            decision = centre;
        end else begin
            decision = '0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= edge_pkg::prologue;
            col <= '0;
            row <= '0;
            read_count <= '0;
        end else begin
            if (in_rd_en) begin
                read_count <= read_count + 1'b1;
            end

            case (state)
                edge_pkg::prologue: begin
                    if (in_rd_en && read_count == PROLOGUE_LAST) begin
                        state <= edge_pkg::decide;
                    end
                end

                edge_pkg::decide: begin
                    // The decision is taken on the same edge as the shift
                    if (shift_en) begin
                        state <= edge_pkg::emit;
                    end
                end

                edge_pkg::emit: begin
                    if (out_wr_en) begin
                        if (last_pixel) begin
                            // Frame done so the next one starts with a fresh prologue
                            state <= edge_pkg::prologue;
                            col <= '0;
                            row <= '0;
                            read_count <= '0;
                        end else begin
                            state <= edge_pkg::decide;
                            if (col == LAST_COL) begin
                                col <= '0;
                                row <= row + 1'b1;
                            end else begin
                                col <= col + 1'b1;
                            end
                        end
                    end
                end

                default: begin
                    state <= edge_pkg::prologue;
                end
            endcase
        end
    end

    // Shift the window and capture the decision for the emit state
    always_ff @(posedge clock) begin
        if (shift_en) begin
            for (int i = 0; i < TAPS - 1; i++) begin
                shift_reg[i] <= shift_reg[i + 1];
            end
            shift_reg[TAPS - 1] <= shift_in;
        end
        if (state == edge_pkg::decide && shift_en) begin
            result <= decision;
        end
    end

endmodule

/* logic/pixel_fifo.sv */
module pixel_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  edge_pkg::pixel_t din,
    output logic             full,
    input  logic             rd_en,
    output edge_pkg::pixel_t dout,
    output logic             empty
);

    localparam int ADDR_BITS = $clog2(FIFO_DEPTH);

    // Circular pixel storage addressed by the low pointer bits
    edge_pkg::pixel_t mem [FIFO_DEPTH];

    // The extra top bit tells a full FIFO apart from an empty one
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;

    logic write_fire;
    logic read_fire;

    assign write_fire = wr_en && !full;
    assign read_fire = rd_en && !empty;

    // Same address with the wrap bit equal means nothing is stored
    assign empty = (wr_ptr == rd_ptr);

    // Same address with the wrap bit different means every slot is taken
    assign full = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS]) &&
                  (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

    // First word fall-through, so the head pixel is visible with no read latency
    assign dout = mem[rd_ptr[ADDR_BITS-1:0]];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (read_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_fire) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= din;
        end
    end

endmodule

/* sim.f */
+incdir+include
logic/edge_pkg.sv
logic/pixel_fifo.sv
logic/hysteresis.sv
logic/edge_link_top.sv
tb/edge_link_tb.sv

/* include/hysteresis_golden.svh */
`ifndef HYSTERESIS_GOLDEN_SVH
`define HYSTERESIS_GOLDEN_SVH

// Reference model of the double-threshold rule on a whole frame held in raster order

function automatic bit above_high(input edge_pkg::pixel_t value);
    return value > edge_pkg::high_threshold;
endfunction

function automatic bit above_low(input edge_pkg::pixel_t value);
    return value > edge_pkg::low_threshold;
endfunction

// Expected output for the pixel at row and col of the frame
function automatic edge_pkg::pixel_t expected_pixel(
    input edge_pkg::pixel_t frame[],
    input int width,
    input int height,
    input int row,
    input int col
);
    edge_pkg::pixel_t centre;
    bit strong_near;
    if (row == 0 || row == height - 1 || col == 0 || col == width - 1) begin
        return '0;
    end
    centre = frame[row * width + col];
    strong_near = 1'b0;
    for (int dr = -1; dr <= 1; dr++) begin
        for (int dc = -1; dc <= 1; dc++) begin
            if ((dr != 0 || dc != 0) &&
                above_high(frame[(row + dr) * width + col + dc])) begin
                strong_near = 1'b1;
            end
        end
    end
    if (above_high(centre) || (above_low(centre) && strong_near)) begin
        return centre;
    end
    return '0;
endfunction

// Appends the expected output frame to the queue, in raster order
function automatic void append_expected_frame(
    input edge_pkg::pixel_t frame[],
    input int width,
    input int height,
    ref edge_pkg::pixel_t expected[$]
);
    for (int row = 0; row < height; row++) begin
        for (int col = 0; col < width; col++) begin
            expected.push_back(expected_pixel(frame, width, height, row, col));
        end
    end
endfunction

`endif

/* tb/edge_link_tb.sv */
`include "hysteresis_golden.svh"

module edge_link_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIDTH = 8;
    localparam int HEIGHT = 6;
    localparam int FIFO_DEPTH = 8;
    localparam int PIXELS = WIDTH * HEIGHT;
    localparam int ROWS = 10;
    localparam int WATCHDOG_CYCLES = 200 * ROWS * PIXELS + 1000;

    typedef enum {
        pat_zeros,
        pat_constant,
        pat_single,
        pat_weak_strong,
        pat_thresholds,
        pat_random
    } pattern_t;

    // One frame of the stimulus table
    typedef struct {
        pattern_t kind;
        int       fill;
        bit       stall;
    } frame_row_t;

    logic             clock;
    logic             reset;
    logic             in_wr_en;
    edge_pkg::pixel_t in_din;
    logic             in_full;
    logic             out_rd_en;
    edge_pkg::pixel_t out_dout;
    logic             out_empty;

    frame_row_t       table_rows [ROWS];
    edge_pkg::pixel_t input_q[$];
    edge_pkg::pixel_t expected_q[$];
    int               frame_counts [ROWS];
    integer           seed;

    edge_link_top #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_edge_link_top (
        .clock(clock),
        .reset(reset),
        .in_wr_en(in_wr_en),
        .in_din(in_din),
        .in_full(in_full),
        .out_rd_en(out_rd_en),
        .out_dout(out_dout),
        .out_empty(out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Raster index of a pixel in the test frame
    function automatic int pixel_index(input int row, input int col);
        return row * WIDTH + col;
    endfunction

    function automatic void build_frame(input pattern_t kind, input int fill,
                                        ref edge_pkg::pixel_t frame[]);
        frame = new[PIXELS];
        for (int i = 0; i < PIXELS; i++) begin
            if (kind == pat_constant) begin
                frame[i] = edge_pkg::pixel_t'(fill);
            end else if (kind == pat_random) begin
                frame[i] = edge_pkg::pixel_t'(($random(seed) & 32'h7fff_ffff) % fill);
            end else begin
                frame[i] = '0;
            end
        end
        case (kind)
            pat_single: begin
                // Interior strong pixel plus strong corners that must come out as zero
                frame[pixel_index(3, 4)] = edge_pkg::pixel_t'(fill);
                frame[pixel_index(0, 0)] = 8'd200;
                frame[pixel_index(0, WIDTH - 1)] = 8'd200;
                frame[pixel_index(HEIGHT - 1, 0)] = 8'd200;
                frame[pixel_index(HEIGHT - 1, WIDTH - 1)] = 8'd200;
            end
            pat_weak_strong: begin
                frame[pixel_index(2, 2)] = 8'd100;
                frame[pixel_index(2, 3)] = edge_pkg::pixel_t'(fill);
                frame[pixel_index(4, 5)] = edge_pkg::pixel_t'(fill);
            end
            pat_thresholds: begin
                // A 3x3 block at exactly the high level has no strong pixel in it
                for (int r = 1; r <= 3; r++) begin
                    for (int c = 1; c <= 3; c++) begin
                        frame[pixel_index(r, c)] = 8'd48;
                    end
                end
                frame[pixel_index(2, 5)] = 8'd13;
                frame[pixel_index(2, 6)] = 8'd49;
                frame[pixel_index(4, 5)] = 8'd12;
                frame[pixel_index(4, 6)] = 8'd49;
            end
            default: begin
            end
        endcase
    endfunction

    task automatic load_table();
        table_rows[0] = '{pat_zeros, 0, 1'b0};
        table_rows[1] = '{pat_constant, 200, 1'b0};
        table_rows[2] = '{pat_single, 100, 1'b0};
        table_rows[3] = '{pat_weak_strong, 30, 1'b0};
        table_rows[4] = '{pat_thresholds, 0, 1'b0};
        table_rows[5] = '{pat_random, 64, 1'b0};
        table_rows[6] = '{pat_random, 64, 1'b0};
        table_rows[7] = '{pat_random, 80, 1'b1};
        table_rows[8] = '{pat_random, 256, 1'b1};
        table_rows[9] = '{pat_constant, 255, 1'b1};
    endtask

    task automatic prepare_frames();
        edge_pkg::pixel_t frame[];
        for (int f = 0; f < ROWS; f++) begin
            build_frame(table_rows[f].kind, table_rows[f].fill, frame);
            foreach (frame[i]) begin
                input_q.push_back(frame[i]);
            end
            append_expected_frame(frame, WIDTH, HEIGHT, expected_q);
            frame_counts[f] = 0;
        end
    endtask

    task automatic check_pixel(input edge_pkg::pixel_t expected, input edge_pkg::pixel_t actual,
                               input int index);
        if (actual !== expected) begin
            $display("ERROR out_dout pixel %0d: expected %h, got %h", index, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Output pixel mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("ERROR %s: expected %h, got %h", name, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "FIFO flag mismatch");
        end
    endtask

    task automatic check_count(input int frame, input int expected, input int actual);
        if (actual != expected) begin
            $display("ERROR frame_count frame %0d: expected %h, got %h", frame, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Wrong number of output pixels");
        end
    endtask

    task automatic feed_pixels();
        int idx;
        idx = 0;
        while (idx < input_q.size()) begin
            @(negedge clock);
            if (!in_full) begin
                in_wr_en = 1'b1;
                in_din = input_q[idx];
                idx++;
            end else begin
                in_wr_en = 1'b0;
            end
        end
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    task automatic drain_pixels();
        int received;
        int stall_left;
        int frame;
        received = 0;
        stall_left = 0;
        while (received < expected_q.size()) begin
            @(negedge clock);
            frame = received / PIXELS;
            if (stall_left > 0) begin
                stall_left--;
                out_rd_en = 1'b0;
            end else if (table_rows[frame].stall && ($random(seed) & 3) == 0) begin
                // Long enough to fill the output FIFO and back up the input one
                stall_left = 1 + (($random(seed) & 32'h7fff_ffff) % 32);
                out_rd_en = 1'b0;
            end else if (!out_empty) begin
                out_rd_en = 1'b1;
                check_pixel(expected_q[received], out_dout, received);
                frame_counts[frame]++;
                received++;
            end else begin
                out_rd_en = 1'b0;
            end
        end
        // Any pixel after the last expected one counts against the final frame
        repeat (4 * WIDTH) begin
            @(negedge clock);
            if (!out_empty) begin
                out_rd_en = 1'b1;
                frame_counts[ROWS - 1]++;
            end else begin
                out_rd_en = 1'b0;
            end
        end
        @(negedge clock);
        out_rd_en = 1'b0;
    endtask

    initial begin
        seed = 43247;
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_din = '0;
        out_rd_en = 1'b0;
        load_table();
        prepare_frames();
        repeat (5) @(posedge clock);
        @(negedge clock);
        // Both FIFOs come out of reset empty
        check_flag("out_empty", 1'b1, out_empty);
        check_flag("in_full", 1'b0, in_full);
        reset = 1'b0;
        fork
            feed_pixels();
            drain_pixels();
        join
        for (int f = 0; f < ROWS; f++) begin
            check_count(f, PIXELS, frame_counts[f]);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: output pixels stopped arriving before the table was done");
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
